// File: rtl/coreCfgPkg.sv
`default_nettype none

package coreCfgPkg;

  localparam int unsigned DISPATCH_WIDTH      = 4;   // Instructions per bundle
  localparam int unsigned DISPATCH_CNT_W      = 3;   // Holds a count of 0 to DISPATCH_WIDTH

  localparam int unsigned CHECKPOINTS         = 8;   // Also the branch-mask width
  localparam int unsigned CHECKPOINTS_LOG     = 3;

  localparam int unsigned SIZE_LSQ            = 16;  // Per queue, loads and stores alike
  localparam int unsigned SIZE_LSQ_LOG        = 4;
  localparam int unsigned SIZE_ISSUEQ         = 32;
  localparam int unsigned SIZE_ISSUEQ_LOG     = 5;
  localparam int unsigned SIZE_ACTIVELIST     = 64;
  localparam int unsigned SIZE_ACTIVELIST_LOG = 6;

  localparam int unsigned SIZE_PHYSICAL_LOG   = 7;   // Physical register tag
  localparam int unsigned SIZE_RMT_LOG        = 5;   // Logical register number
  localparam int unsigned SIZE_PC             = 32;

  // Occupancy plus a full bundle must not wrap, so sums get one spare bit
  localparam int unsigned LSQ_SUM_W           = SIZE_LSQ_LOG + 2;
  localparam int unsigned ISSUEQ_SUM_W        = SIZE_ISSUEQ_LOG + 2;
  localparam int unsigned ACTIVELIST_SUM_W    = SIZE_ACTIVELIST_LOG + 2;

endpackage

`default_nettype wire

// File: rtl/dispatchPktPkg.sv
`default_nettype none

package dispatchPktPkg;

  // One instruction as it leaves rename
  typedef struct packed {
    logic [coreCfgPkg::SIZE_RMT_LOG-1:0]      logDest;
    logic                                     isStore;
    logic                                     isLoad;
    logic [coreCfgPkg::CHECKPOINTS-1:0]       branchMask;  // Unresolved branches it depends on
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] oldPhyDest;  // Freed at retire
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [coreCfgPkg::SIZE_PC-1:0]           pc;
  } renamedInstT;

  typedef struct packed {
    renamedInstT [coreCfgPkg::DISPATCH_WIDTH-1:0] lane;
  } renamedBundleT;

  // Issue queue entry
  typedef struct packed {
    logic                                     isStore;
    logic                                     isLoad;
    logic [coreCfgPkg::CHECKPOINTS-1:0]       branchMask;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [coreCfgPkg::SIZE_PC-1:0]           pc;
  } iqPktT;

  // Active list entry
  typedef struct packed {
    logic                                     isLoad;
    logic                                     isStore;
    logic [coreCfgPkg::SIZE_PC-1:0]           pc;
    logic [coreCfgPkg::SIZE_RMT_LOG-1:0]      logDest;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
  } alPktT;

  // Load-store queue entry
  typedef struct packed {
    logic [coreCfgPkg::CHECKPOINTS-1:0] branchMask;
    logic                               isStore;
    logic                               isLoad;
  } lsqPktT;

  typedef struct packed {
    iqPktT [coreCfgPkg::DISPATCH_WIDTH-1:0] lane;
  } iqBundleT;

  typedef struct packed {
    alPktT [coreCfgPkg::DISPATCH_WIDTH-1:0] lane;
  } alBundleT;

  typedef struct packed {
    lsqPktT [coreCfgPkg::DISPATCH_WIDTH-1:0] lane;
  } lsqBundleT;

  // Current back-end fill levels
  typedef struct packed {
    logic [coreCfgPkg::SIZE_LSQ_LOG:0]        loadQueueCnt;
    logic [coreCfgPkg::SIZE_LSQ_LOG:0]        storeQueueCnt;
    logic [coreCfgPkg::SIZE_ISSUEQ_LOG:0]     issueQueueCnt;
    logic [coreCfgPkg::SIZE_ACTIVELIST_LOG:0] activeListCnt;
  } occupancyT;

  // A control instruction resolved as predicted
  typedef struct packed {
    logic                                   verified;
    logic [coreCfgPkg::CHECKPOINTS_LOG-1:0] checkpointId;
  } ctrlVerifyT;

endpackage

`default_nettype wire

// File: rtl/renameDispatchLatch.sv
`timescale 1ns/1ns
`default_nettype none

module renameDispatchLatch (
  input  wire                          clk,
  input  wire                          rstN_i,
  input  wire                          renameReady_i,    // Rename has a new bundle
  input  wire                          stall_i,          // External back-end stall
  input  wire                          flagRecoverEX_i,  // Misprediction recovery
  input  wire                          noSpace_i,        // Some queue lacks room
  input  dispatchPktPkg::renamedBundleT renamedBundle_i,
  input  dispatchPktPkg::renamedBundleT refreshedBundle_i, // Held bundle with updated masks
  output dispatchPktPkg::renamedBundleT heldBundle_o,
  output logic                         backEndReady_o,
  output logic                         stallfrontEnd_o
);

  dispatchPktPkg::renamedBundleT bundleQ;
  logic                          validQ;
  logic                          holdBundle;

  // Bundle cannot leave this cycle
  assign holdBundle = validQ & (stall_i | noSpace_i);

  // Valid flag follows the latch priority
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= 1'b0;
    end else if (flagRecoverEX_i) begin
      validQ <= 1'b0;                         // Squash whatever sits here
    end else if (holdBundle) begin
      validQ <= 1'b1;
    end else begin
      validQ <= renameReady_i;
    end
  end

  // A held bundle recirculates so that resolved branches keep clearing its masks
  always_ff @(posedge clk) begin
    if (holdBundle) begin
      bundleQ <= refreshedBundle_i;
    end else begin
      bundleQ <= renamedBundle_i;
    end
  end

  assign heldBundle_o = bundleQ;

  assign stallfrontEnd_o = validQ & noSpace_i;
  assign backEndReady_o  = validQ & ~noSpace_i & ~stall_i & ~flagRecoverEX_i; // Packets accepted

endmodule

`default_nettype wire

// File: rtl/dispatchResourceCheck.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchResourceCheck (
  input  dispatchPktPkg::renamedBundleT heldBundle_i,
  input  dispatchPktPkg::occupancyT     occupancy_i,
  output logic                         noSpace_o
);

  logic [coreCfgPkg::DISPATCH_CNT_W-1:0]   loadCnt;
  logic [coreCfgPkg::DISPATCH_CNT_W-1:0]   storeCnt;

  logic [coreCfgPkg::LSQ_SUM_W-1:0]        loadSum;
  logic [coreCfgPkg::LSQ_SUM_W-1:0]        storeSum;
  logic [coreCfgPkg::ISSUEQ_SUM_W-1:0]     issueSum;
  logic [coreCfgPkg::ACTIVELIST_SUM_W-1:0] activeSum;

  logic loadStall;
  logic storeStall;
  logic issueStall;
  logic activeStall;

  // Count memory operations in the held bundle
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      loadCnt  = loadCnt  + coreCfgPkg::DISPATCH_CNT_W'(heldBundle_i.lane[i].isLoad);
      storeCnt = storeCnt + coreCfgPkg::DISPATCH_CNT_W'(heldBundle_i.lane[i].isStore);
    end
  end

  assign loadSum   = coreCfgPkg::LSQ_SUM_W'(occupancy_i.loadQueueCnt)
                   + coreCfgPkg::LSQ_SUM_W'(loadCnt);
  assign storeSum  = coreCfgPkg::LSQ_SUM_W'(occupancy_i.storeQueueCnt)
                   + coreCfgPkg::LSQ_SUM_W'(storeCnt);

  // Every lane takes an IQ and AL slot whatever its type
  assign issueSum  = coreCfgPkg::ISSUEQ_SUM_W'(occupancy_i.issueQueueCnt)
                   + coreCfgPkg::ISSUEQ_SUM_W'(coreCfgPkg::DISPATCH_WIDTH);
  assign activeSum = coreCfgPkg::ACTIVELIST_SUM_W'(occupancy_i.activeListCnt)
                   + coreCfgPkg::ACTIVELIST_SUM_W'(coreCfgPkg::DISPATCH_WIDTH);

  assign loadStall   = loadSum   > coreCfgPkg::LSQ_SUM_W'(coreCfgPkg::SIZE_LSQ);
  assign storeStall  = storeSum  > coreCfgPkg::LSQ_SUM_W'(coreCfgPkg::SIZE_LSQ);
  assign issueStall  = issueSum  > coreCfgPkg::ISSUEQ_SUM_W'(coreCfgPkg::SIZE_ISSUEQ);
  assign activeStall = activeSum > coreCfgPkg::ACTIVELIST_SUM_W'(coreCfgPkg::SIZE_ACTIVELIST);

  assign noSpace_o = loadStall | storeStall | issueStall | activeStall;

endmodule

`default_nettype wire

// File: rtl/dispatchPacketBuilder.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchPacketBuilder (
  input  dispatchPktPkg::renamedBundleT heldBundle_i,
  input  dispatchPktPkg::ctrlVerifyT    ctrlVerify_i,
  output dispatchPktPkg::renamedBundleT refreshedBundle_o, // Back to the latch
  output dispatchPktPkg::iqBundleT      iqBundle_o,
  output dispatchPktPkg::alBundleT      alBundle_o,
  output dispatchPktPkg::lsqBundleT     lsqBundle_o
);

  logic [coreCfgPkg::CHECKPOINTS-1:0] clearMask;
  dispatchPktPkg::renamedBundleT      updBundle;

  // One-hot of the checkpoint freed by a correctly predicted branch
  always_comb begin
    clearMask = '0;
    if (ctrlVerify_i.verified) begin
      clearMask[ctrlVerify_i.checkpointId] = 1'b1;
    end
  end

  always_comb begin
    updBundle = heldBundle_i;
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      updBundle.lane[i].branchMask = heldBundle_i.lane[i].branchMask & ~clearMask;
    end
  end

  assign refreshedBundle_o = updBundle;

  // Split each updated lane into its three back-end packets
  always_comb begin
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      iqBundle_o.lane[i].isStore     = updBundle.lane[i].isStore;
      iqBundle_o.lane[i].isLoad      = updBundle.lane[i].isLoad;
      iqBundle_o.lane[i].branchMask  = updBundle.lane[i].branchMask;
      iqBundle_o.lane[i].phySrc1     = updBundle.lane[i].phySrc1;
      iqBundle_o.lane[i].phySrc2     = updBundle.lane[i].phySrc2;
      iqBundle_o.lane[i].phyDest     = updBundle.lane[i].phyDest;
      iqBundle_o.lane[i].pc          = updBundle.lane[i].pc;

      alBundle_o.lane[i].isLoad      = updBundle.lane[i].isLoad;
      alBundle_o.lane[i].isStore     = updBundle.lane[i].isStore;
      alBundle_o.lane[i].pc          = updBundle.lane[i].pc;       // Needed for precise exceptions
      alBundle_o.lane[i].logDest     = updBundle.lane[i].logDest;
      alBundle_o.lane[i].phyDest     = updBundle.lane[i].phyDest;
      alBundle_o.lane[i].oldPhyDest  = updBundle.lane[i].oldPhyDest;

      lsqBundle_o.lane[i].branchMask = updBundle.lane[i].branchMask;
      lsqBundle_o.lane[i].isStore    = updBundle.lane[i].isStore;
      lsqBundle_o.lane[i].isLoad     = updBundle.lane[i].isLoad;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dispatchTop.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchTop (
  input  wire                          clk,
  input  wire                          rstN_i,
  input  wire                          renameReady_i,
  input  wire                          stall_i,
  input  wire                          flagRecoverEX_i,
  input  dispatchPktPkg::renamedBundleT renamedBundle_i,
  input  dispatchPktPkg::occupancyT     occupancy_i,
  input  dispatchPktPkg::ctrlVerifyT    ctrlVerify_i,
  output dispatchPktPkg::iqBundleT      iqBundle_o,
  output dispatchPktPkg::alBundleT      alBundle_o,
  output dispatchPktPkg::lsqBundleT     lsqBundle_o,
  output logic                         backEndReady_o,
  output logic                         stallfrontEnd_o
);

  dispatchPktPkg::renamedBundleT heldBundle;       // Latch contents
  dispatchPktPkg::renamedBundleT refreshedBundle;  // Same bundle after mask clearing
  logic                          noSpace;

  renameDispatchLatch u_renameDispatchLatch (
    .clk               (clk),
    .rstN_i            (rstN_i),
    .renameReady_i     (renameReady_i),
    .stall_i           (stall_i),
    .flagRecoverEX_i   (flagRecoverEX_i),
    .noSpace_i         (noSpace),
    .renamedBundle_i   (renamedBundle_i),
    .refreshedBundle_i (refreshedBundle),
    .heldBundle_o      (heldBundle),
    .backEndReady_o    (backEndReady_o),
    .stallfrontEnd_o   (stallfrontEnd_o)
  );

  dispatchResourceCheck u_dispatchResourceCheck (
    .heldBundle_i (heldBundle),
    .occupancy_i  (occupancy_i),
    .noSpace_o    (noSpace)
  );

  dispatchPacketBuilder u_dispatchPacketBuilder (
    .heldBundle_i      (heldBundle),
    .ctrlVerify_i      (ctrlVerify_i),
    .refreshedBundle_o (refreshedBundle),
    .iqBundle_o        (iqBundle_o),
    .alBundle_o        (alBundle_o),
    .lsqBundle_o       (lsqBundle_o)
  );

endmodule

`default_nettype wire

// File: tb/dispatchTop_chk.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchTopChk (
  input wire clk,
  input wire rstN_i,
  input wire flagRecoverEX_i,
  input wire backEndReady_i,   // DUT backEndReady_o
  input wire stallFrontEnd_i   // DUT stallfrontEnd_o
);

  // A bundle either leaves or stalls the front end, never both
  readyStallExclusive: assert property (
    @(posedge clk) disable iff (!rstN_i) !(backEndReady_i && stallFrontEnd_i)
  ) else $error("backEndReady_o and stallfrontEnd_o are high together");

  // Recovery squashes the bundle in the same cycle
  noReadyDuringRecover: assert property (
    @(posedge clk) disable iff (!rstN_i) !(backEndReady_i && flagRecoverEX_i)
  ) else $error("backEndReady_o is high while flagRecoverEX_i is high");

  // The latch is empty for one cycle after a recovery
  quietAfterRecover: assert property (
    @(posedge clk) disable iff (!rstN_i)
      flagRecoverEX_i |=> (!backEndReady_i && !stallFrontEnd_i)
  ) else $error("Control outputs active in the cycle after a recovery");

endmodule

bind dispatchTop dispatchTopChk u_dispatchTopChk (
  .clk             (clk),
  .rstN_i          (rstN_i),
  .flagRecoverEX_i (flagRecoverEX_i),
  .backEndReady_i  (backEndReady_o),
  .stallFrontEnd_i (stallfrontEnd_o)
);

`default_nettype wire

// File: tb/dispatchTb.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchTb;

  localparam int unsigned RUN_CYCLES      = 2000;
  localparam int unsigned WATCHDOG_CYCLES = 3000;
  localparam int unsigned CAPTURE_TIMEOUT = 40;

  logic                          clk;
  logic                          rstN;
  logic                          renameReady;
  logic                          stall;
  logic                          recover;
  dispatchPktPkg::renamedBundleT renamedBundle;
  dispatchPktPkg::occupancyT     occupancy;
  dispatchPktPkg::ctrlVerifyT    ctrlVerify;
  dispatchPktPkg::iqBundleT      iqBundle;
  dispatchPktPkg::alBundleT      alBundle;
  dispatchPktPkg::lsqBundleT     lsqBundle;
  logic                          backEndReady;
  logic                          stallFrontEnd;

  logic [15:0]                   lfsrState;
  logic                          modelValid;    // Model of the latch valid flag
  dispatchPktPkg::renamedBundleT modelBundle;   // Model of the latch contents
  logic                          quietFrontEnd; // Rename idle, no stall, no recovery
  logic                          forceCapture;  // Rename always ready, no stall or recovery
  logic                          sawReady;
  int unsigned                   dispatched;
  int unsigned                   stalled;

  dispatchTop u_dispatchTop (
    .clk             (clk),
    .rstN_i          (rstN),
    .renameReady_i   (renameReady),
    .stall_i         (stall),
    .flagRecoverEX_i (recover),
    .renamedBundle_i (renamedBundle),
    .occupancy_i     (occupancy),
    .ctrlVerify_i    (ctrlVerify),
    .iqBundle_o      (iqBundle),
    .alBundle_o      (alBundle),
    .lsqBundle_o     (lsqBundle),
    .backEndReady_o  (backEndReady),
    .stallfrontEnd_o (stallFrontEnd)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] randBits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);  // One step per bit
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic logic [coreCfgPkg::SIZE_PHYSICAL_LOG-1:0] randTag();
    return coreCfgPkg::SIZE_PHYSICAL_LOG'(randBits(coreCfgPkg::SIZE_PHYSICAL_LOG));
  endfunction

  function automatic dispatchPktPkg::renamedBundleT randomBundle();
    dispatchPktPkg::renamedBundleT b;
    logic [1:0]                    kind;
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      kind                 = 2'(randBits(2));   // 1 load, 2 store, else neither
      b.lane[i].logDest    = coreCfgPkg::SIZE_RMT_LOG'(randBits(coreCfgPkg::SIZE_RMT_LOG));
      b.lane[i].isLoad     = (kind == 2'd1);
      b.lane[i].isStore    = (kind == 2'd2);
      b.lane[i].branchMask = coreCfgPkg::CHECKPOINTS'(randBits(coreCfgPkg::CHECKPOINTS));
      b.lane[i].phyDest    = randTag();
      b.lane[i].oldPhyDest = randTag();
      b.lane[i].phySrc1    = randTag();
      b.lane[i].phySrc2    = randTag();
      b.lane[i].pc         = coreCfgPkg::SIZE_PC'(randBits(coreCfgPkg::SIZE_PC));
    end
    return b;
  endfunction

  function automatic int unsigned countMemOps(input dispatchPktPkg::renamedBundleT b,
                                              input logic wantStore);
    int unsigned n;
    n = 0;
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      if (wantStore ? b.lane[i].isStore : b.lane[i].isLoad) begin
        n++;
      end
    end
    return n;
  endfunction

  // Fill level relative to the last one that still fits, clamped to the capacity
  function automatic int unsigned fitLevel(input int unsigned cap, input int unsigned used,
                                           input int delta);
    int v;
    v = int'(cap) - int'(used) + delta;
    if (v < 0) v = 0;
    if (v > int'(cap)) v = int'(cap);
    return unsigned'(v);
  endfunction

  function automatic logic modelNoSpace(input dispatchPktPkg::renamedBundleT b,
                                        input dispatchPktPkg::occupancyT occ);
    int loads;
    int stores;
    loads  = int'(countMemOps(b, 1'b0));
    stores = int'(countMemOps(b, 1'b1));
    return (int'(occ.loadQueueCnt) + loads > int'(coreCfgPkg::SIZE_LSQ))
        || (int'(occ.storeQueueCnt) + stores > int'(coreCfgPkg::SIZE_LSQ))
        || (int'(occ.issueQueueCnt) + int'(coreCfgPkg::DISPATCH_WIDTH)
            > int'(coreCfgPkg::SIZE_ISSUEQ))
        || (int'(occ.activeListCnt) + int'(coreCfgPkg::DISPATCH_WIDTH)
            > int'(coreCfgPkg::SIZE_ACTIVELIST));
  endfunction

  function automatic dispatchPktPkg::renamedBundleT clearVerified(
      input dispatchPktPkg::renamedBundleT b, input dispatchPktPkg::ctrlVerifyT cv);
    dispatchPktPkg::renamedBundleT r;
    r = b;
    if (cv.verified) begin
      for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
        r.lane[i].branchMask[cv.checkpointId] = 1'b0;  // Branch resolved as predicted
      end
    end
    return r;
  endfunction

  task automatic buildExpected(input dispatchPktPkg::renamedBundleT b,
                               output dispatchPktPkg::iqBundleT iq,
                               output dispatchPktPkg::alBundleT al,
                               output dispatchPktPkg::lsqBundleT lsq);
    for (int i = 0; i < coreCfgPkg::DISPATCH_WIDTH; i++) begin
      iq.lane[i].isStore     = b.lane[i].isStore;
      iq.lane[i].isLoad      = b.lane[i].isLoad;
      iq.lane[i].branchMask  = b.lane[i].branchMask;
      iq.lane[i].phySrc1     = b.lane[i].phySrc1;
      iq.lane[i].phySrc2     = b.lane[i].phySrc2;
      iq.lane[i].phyDest     = b.lane[i].phyDest;
      iq.lane[i].pc          = b.lane[i].pc;
      al.lane[i].isLoad      = b.lane[i].isLoad;
      al.lane[i].isStore     = b.lane[i].isStore;
      al.lane[i].pc          = b.lane[i].pc;
      al.lane[i].logDest     = b.lane[i].logDest;
      al.lane[i].phyDest     = b.lane[i].phyDest;
      al.lane[i].oldPhyDest  = b.lane[i].oldPhyDest;
      lsq.lane[i].branchMask = b.lane[i].branchMask;
      lsq.lane[i].isStore    = b.lane[i].isStore;
      lsq.lane[i].isLoad     = b.lane[i].isLoad;
    end
  endtask

  task automatic stopOnError();
    $display("TEST FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic checkIq(input dispatchPktPkg::iqBundleT got,
                         input dispatchPktPkg::iqBundleT exp);
    if (got !== exp) begin
      $display("Fail iqBundle_o: got 0x%h expected 0x%h", got, exp);
      stopOnError();
    end
  endtask

  task automatic checkAl(input dispatchPktPkg::alBundleT got,
                         input dispatchPktPkg::alBundleT exp);
    if (got !== exp) begin
      $display("Fail alBundle_o: got 0x%h expected 0x%h", got, exp);
      stopOnError();
    end
  endtask

  task automatic checkLsq(input dispatchPktPkg::lsqBundleT got,
                          input dispatchPktPkg::lsqBundleT exp);
    if (got !== exp) begin
      $display("Fail lsqBundle_o: got 0x%h expected 0x%h", got, exp);
      stopOnError();
    end
  endtask

  task automatic checkCtrl(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      stopOnError();
    end
  endtask

  // Called 1 ns after the rising edge
  task automatic drawInputs();
    int unsigned loads;
    int unsigned stores;
    logic [1:0]  pick;
    int          delta;
    renamedBundle = randomBundle();
    renameReady   = forceCapture | (randBits(2) != 0);
    stall         = ~forceCapture & (randBits(3) == 0);
    recover       = ~forceCapture & (randBits(4) == 0);
    if (quietFrontEnd) begin
      renameReady = 1'b0;
      stall       = 1'b0;
      recover     = 1'b0;
    end
    ctrlVerify.verified     = (randBits(1) != 0);
    ctrlVerify.checkpointId = coreCfgPkg::CHECKPOINTS_LOG'(randBits(coreCfgPkg::CHECKPOINTS_LOG));
    // Comfortable levels, then one queue placed around its boundary
    occupancy.loadQueueCnt  = (coreCfgPkg::SIZE_LSQ_LOG + 1)'(randBits(3));
    occupancy.storeQueueCnt = (coreCfgPkg::SIZE_LSQ_LOG + 1)'(randBits(3));
    occupancy.issueQueueCnt = (coreCfgPkg::SIZE_ISSUEQ_LOG + 1)'(randBits(4));
    occupancy.activeListCnt = (coreCfgPkg::SIZE_ACTIVELIST_LOG + 1)'(randBits(5));
    pick   = 2'(randBits(2));
    delta  = int'(randBits(2)) - 2;  // Plus one is just past the boundary
    loads  = countMemOps(modelBundle, 1'b0);
    stores = countMemOps(modelBundle, 1'b1);
    case (pick)
      2'd0: occupancy.loadQueueCnt = (coreCfgPkg::SIZE_LSQ_LOG + 1)'(
              fitLevel(coreCfgPkg::SIZE_LSQ, loads, delta));
      2'd1: occupancy.storeQueueCnt = (coreCfgPkg::SIZE_LSQ_LOG + 1)'(
              fitLevel(coreCfgPkg::SIZE_LSQ, stores, delta));
      2'd2: occupancy.issueQueueCnt = (coreCfgPkg::SIZE_ISSUEQ_LOG + 1)'(
              fitLevel(coreCfgPkg::SIZE_ISSUEQ, coreCfgPkg::DISPATCH_WIDTH, delta));
      default: occupancy.activeListCnt = (coreCfgPkg::SIZE_ACTIVELIST_LOG + 1)'(
              fitLevel(coreCfgPkg::SIZE_ACTIVELIST, coreCfgPkg::DISPATCH_WIDTH, delta));
    endcase
  endtask

  // Called 1 ns before the rising edge
  task automatic checkAndStep();
    dispatchPktPkg::renamedBundleT upd;
    dispatchPktPkg::iqBundleT      expIq;
    dispatchPktPkg::alBundleT      expAl;
    dispatchPktPkg::lsqBundleT     expLsq;
    logic                          noSpace;
    logic                          expReady;
    logic                          expStall;
    upd      = clearVerified(modelBundle, ctrlVerify);
    buildExpected(upd, expIq, expAl, expLsq);
    noSpace  = modelNoSpace(modelBundle, occupancy);
    expStall = modelValid & noSpace;
    expReady = modelValid & ~noSpace & ~stall & ~recover;
    checkCtrl("backEndReady_o", backEndReady, expReady);
    checkCtrl("stallfrontEnd_o", stallFrontEnd, expStall);
    if (modelValid) begin  // Packet contents only matter for a valid bundle
      checkIq(iqBundle, expIq);
      checkAl(alBundle, expAl);
      checkLsq(lsqBundle, expLsq);
    end
    if (backEndReady) begin
      sawReady = 1'b1;
      dispatched++;
    end
    if (stallFrontEnd) stalled++;
    if (recover) begin
      modelValid = 1'b0;
    end else if (modelValid && (stall || noSpace)) begin
      modelBundle = upd;  // Held, masks keep clearing
    end else begin
      modelBundle = renamedBundle;
      modelValid  = renameReady;
    end
  endtask

  task automatic runCycle();
    drawInputs();
    #2;
    checkAndStep();
    @(posedge clk);
    #1;
  endtask

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < WATCHDOG_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    stopOnError();
  end

  initial begin : stimulus
    int unsigned waited;
    lfsrState     = 16'd62;
    rstN          = 1'b0;
    renameReady   = 1'b0;
    stall         = 1'b0;
    recover       = 1'b0;
    renamedBundle = '0;
    occupancy     = '0;
    ctrlVerify    = '0;
    modelValid    = 1'b0;
    modelBundle   = '0;
    quietFrontEnd = 1'b1;
    forceCapture  = 1'b0;
    sawReady      = 1'b0;
    dispatched    = 0;
    stalled       = 0;
    waited        = 0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    repeat (4) runCycle();  // Nothing captured, both controls stay low
    quietFrontEnd = 1'b0;
    forceCapture  = 1'b1;
    while (!sawReady && waited < CAPTURE_TIMEOUT) begin
      runCycle();
      waited++;
    end
    if (!sawReady) begin
      $display("No bundle was dispatched within %0d cycles after reset", CAPTURE_TIMEOUT);
      stopOnError();
    end else begin
      forceCapture = 1'b0;
      repeat (RUN_CYCLES) runCycle();
      $display("Dispatched %0d bundles, front end stalled in %0d cycles", dispatched, stalled);
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dispatchStage.f
rtl/coreCfgPkg.sv
rtl/dispatchPktPkg.sv
rtl/renameDispatchLatch.sv
rtl/dispatchResourceCheck.sv
rtl/dispatchPacketBuilder.sv
rtl/dispatchTop.sv
tb/dispatchTop_chk.sv
tb/dispatchTb.sv
